/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tpmSpiCtrlTb
FILELIST = files.f
LOG      = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "sim passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* files.f */
rtl/spiProtocolPkg.sv
rtl/tpmCtrlPkg.sv
rtl/headerDecode.sv
rtl/transferEngine.sv
rtl/txResponder.sv
rtl/tpmSpiCtrl.sv
verification/clockGen.sv
verification/tpmSpiCtrlTb.sv

/* rtl/headerDecode.sv */
/*
 * TPM header collector and decoder.
 * Shifts in the four header bytes, then times the wait phase
 * and latches the register file base address.
 */
`timescale 1ns/1ns

module headerDecode
#(
	parameter int FrsAddrWidth = 16	// low address bits used
)
(
	input logic clock,
	input logic reset_n,
	input tpmCtrlPkg::ctrlPhase_t phase,
	input spiProtocolPkg::byte_t rxByte,
	input logic rxValid,
	output spiProtocolPkg::cmdHeader_t header,
	output logic [FrsAddrWidth-1:0] baseAddr,
	output logic headerDone,
	output logic waitDone
);
	import spiProtocolPkg::*;
	import tpmCtrlPkg::*;

	logic [HeaderBytes:0] byteTrack;	// one-hot, top bit set once full
	logic capture;	// header byte accepted this cycle
	logic waitStage;	// first wait cycle seen

	// bytes past the fourth are not header
	assign capture = (phase == phHeader) && rxValid && !byteTrack[HeaderBytes];

	// header assembly, msb byte first
	always_ff @(posedge clock)
	begin
		if (capture)
			header <= {header[HeaderWidth-$bits(byte_t)-1:0], rxByte};
	end

	// base address taken on first wait cycle
	always_ff @(posedge clock)
	begin
		if ((phase == phWait) && !waitStage)
			baseAddr <= header.addr[FrsAddrWidth-1:0];
	end

	// byte tracking and wait timing
	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			byteTrack <= (HeaderBytes + 1)'(1);
			headerDone <= 1'b0;
			waitStage <= 1'b0;
			waitDone <= 1'b0;
		end
		else if (phase == phIdle)
		begin
			byteTrack <= (HeaderBytes + 1)'(1);	// back to first byte
			headerDone <= 1'b0;
			waitStage <= 1'b0;
			waitDone <= 1'b0;
		end
		else
		begin
			if (capture)
				byteTrack <= byteTrack << 1;
			headerDone <= byteTrack[HeaderBytes];	// one cycle after fourth byte
			if (phase == phWait)
			begin
				waitStage <= 1'b1;
				waitDone <= waitStage;	// two cycles into phWait
			end
		end
	end

endmodule

/* rtl/spiProtocolPkg.sv */
/*
 * SPI serializer and TPM command header formats.
 * Byte type, header layout and transfer direction seen on the wire.
 */
package spiProtocolPkg;

	typedef logic [7:0] byte_t;	// one serializer or register byte

	localparam int HeaderBytes = 4;	// command header length in bytes
	localparam int HeaderWidth = HeaderBytes * $bits(byte_t);
	localparam int SizeWidth = 6;	// size field holds byte count minus one
	localparam int FullAddrWidth = 24;	// full TPM register address

	// sent ahead of the data of every transfer
	localparam byte_t WaitReleaseByte = 8'hFF;

	// header bit 31, set for a read
	typedef enum logic
	{
		dirWrite = 1'b0,
		dirRead = 1'b1
	} transferDir_t;

	// msb first as received from the serializer
	typedef struct packed
	{
		transferDir_t dir;	// bit 31
		logic reserved;	// bit 30, ignored
		logic [SizeWidth-1:0] size;	// bytes minus one
		logic [FullAddrWidth-1:0] addr;	// register address
	} cmdHeader_t;

endpackage

/* rtl/tpmCtrlPkg.sv */
/*
 * Controller sequencing types: transaction phases, engine and
 * responder sub-states, and the register file access bundle.
 */
package tpmCtrlPkg;

	localparam int FrsBusAddrWidth = 16;	// address width on the frs bus

	// transaction phases, broadcast from the top
	typedef enum logic [1:0]
	{
		phIdle,	// chip select high
		phHeader,	// collecting header bytes
		phWait,	// base address latch
		phTransfer	// data movement
	} ctrlPhase_t;

	// transfer engine sub-states
	typedef enum logic [3:0]
	{
		xsIdle,
		xsStart,	// load release byte
		xsRelease,	// wait until release byte sent
		xsWriteLoop,	// receive and write
		xsReadStrobe,	// frs read strobe
		xsLoad,	// read data to responder
		xsSendWait,	// wait until read byte sent
		xsDone	// quiet until chip select rises
	} xferState_t;

	// transmit responder sub-states
	typedef enum logic [2:0]
	{
		rsEmpty,
		rsHold,	// byte pending, no prepare yet
		rsArm,
		rsFire,
		rsValid,	// txValid cycle
		rsAck	// waiting for serializer ack
	} txState_t;

	// one register file access, 26 bits
	typedef struct packed
	{
		logic [FrsBusAddrWidth-1:0] addr;
		spiProtocolPkg::byte_t wrByte;
		logic wrStrobe;	// one cycle per written byte
		logic rdStrobe;	// data returns next cycle
	} frsAccess_t;

endpackage

/* rtl/tpmSpiCtrl.sv */
/*
 * TPM-over-SPI transaction controller.
 * Phase machine for header, wait and transfer, bridging the SPI
 * byte serializer and the byte-wide register file.
 */
`timescale 1ns/1ns

module tpmSpiCtrl
#(
	parameter int FrsAddrWidth = 16	// low address bits used in the frs
)
(
	input logic clock,
	input logic reset_n,
	input logic csN,	// chip select, active low
	input spiProtocolPkg::byte_t rxByte,
	input logic rxValid,
	input logic txPrepare,
	input logic txAck,
	input spiProtocolPkg::byte_t frsRdByte,	// one cycle after rdStrobe
	output spiProtocolPkg::byte_t txByte,
	output logic txValid,
	output tpmCtrlPkg::frsAccess_t frs
);
	import spiProtocolPkg::*;
	import tpmCtrlPkg::*;

	ctrlPhase_t phase;
	cmdHeader_t header;
	logic [FrsAddrWidth-1:0] baseAddr;
	logic headerDone;
	logic waitDone;
	byte_t loadByte;
	logic loadValid;
	logic sent;

	// phase machine, chip select high aborts
	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
			phase <= phIdle;
		else if (csN)
			phase <= phIdle;
		else
			case (phase)
				phIdle:
					phase <= phHeader;
				phHeader:
					if (headerDone)
						phase <= phWait;
				phWait:
					if (waitDone)
						phase <= phTransfer;
				default:
					phase <= phTransfer;	// length set by the engine
			endcase
	end

	headerDecode #(
		.FrsAddrWidth(FrsAddrWidth)
	) i_decode (
		.clock(clock),
		.reset_n(reset_n),
		.phase(phase),
		.rxByte(rxByte),
		.rxValid(rxValid),
		.header(header),
		.baseAddr(baseAddr),
		.headerDone(headerDone),
		.waitDone(waitDone)
	);

	transferEngine #(
		.FrsAddrWidth(FrsAddrWidth)
	) i_execute (
		.clock(clock),
		.reset_n(reset_n),
		.phase(phase),
		.header(header),
		.baseAddr(baseAddr),
		.rxByte(rxByte),
		.rxValid(rxValid),
		.frsRdByte(frsRdByte),
		.sent(sent),
		.frs(frs),
		.loadByte(loadByte),
		.loadValid(loadValid)
	);

	txResponder i_result (
		.clock(clock),
		.reset_n(reset_n),
		.phase(phase),
		.loadByte(loadByte),
		.loadValid(loadValid),
		.txPrepare(txPrepare),
		.txAck(txAck),
		.txByte(txByte),
		.txValid(txValid),
		.sent(sent)
	);

	// transfer only after a complete header in this selection
	assert property (@(posedge clock) disable iff (!reset_n)
		$rose(phase == phTransfer) |-> headerDone);

endmodule

/* rtl/transferEngine.sv */
/*
 * TPM transfer engine.
 * Sends the wait-release byte, then runs either the receive-and-write
 * loop or the read-and-send loop for size+1 bytes.
 */
`timescale 1ns/1ns

module transferEngine
#(
	parameter int FrsAddrWidth = 16	// low address bits used
)
(
	input logic clock,
	input logic reset_n,
	input tpmCtrlPkg::ctrlPhase_t phase,
	input spiProtocolPkg::cmdHeader_t header,
	input logic [FrsAddrWidth-1:0] baseAddr,
	input spiProtocolPkg::byte_t rxByte,
	input logic rxValid,
	input spiProtocolPkg::byte_t frsRdByte,
	input logic sent,	// responder finished a byte
	output tpmCtrlPkg::frsAccess_t frs,
	output spiProtocolPkg::byte_t loadByte,
	output logic loadValid
);
	import spiProtocolPkg::*;
	import tpmCtrlPkg::*;

	xferState_t state;
	logic [FrsAddrWidth-1:0] addrCnt;	// base plus byte index
	logic [SizeWidth-1:0] byteCnt;	// bytes handled so far
	logic lastByte;
	logic accept;	// write data byte taken
	logic rxPend;	// write pipe stage one
	logic wrStrobe;	// write pipe stage two
	byte_t rxData;
	byte_t wrData;
	logic inTransfer;

	assign inTransfer = (phase == phTransfer);
	assign lastByte = (byteCnt == header.size);
	assign accept = (state == xsWriteLoop) && rxValid;

	// sequencer, counters and address
	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= xsIdle;
			byteCnt <= '0;
			addrCnt <= '0;
		end
		else if (phase == phIdle)
		begin
			state <= xsIdle;
			byteCnt <= '0;
			addrCnt <= '0;
		end
		else
		begin
			// address steps after a write strobe or a sent read byte
			if (state == xsStart)
				addrCnt <= baseAddr;
			else if (wrStrobe || ((state == xsSendWait) && sent))
				addrCnt <= addrCnt + FrsAddrWidth'(1);

			case (state)
				xsIdle:
					if (inTransfer)
						state <= xsStart;
				xsStart:
					state <= xsRelease;	// release byte goes out
				xsRelease:
					if (sent)
						state <= (header.dir == dirWrite) ? xsWriteLoop : xsReadStrobe;
				xsWriteLoop:
					if (accept)
					begin
						byteCnt <= byteCnt + SizeWidth'(1);
						if (lastByte)
							state <= xsDone;	// pipe still drains
					end
				xsReadStrobe:
					state <= xsLoad;
				xsLoad:
					state <= xsSendWait;
				xsSendWait:
					if (sent)
					begin
						byteCnt <= byteCnt + SizeWidth'(1);
						state <= lastByte ? xsDone : xsReadStrobe;
					end
				xsDone:
					state <= xsDone;	// held until phIdle
				default:
					state <= xsIdle;
			endcase
		end
	end

	// write pipe, strobe two cycles after rxValid
	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			rxPend <= 1'b0;
			wrStrobe <= 1'b0;
		end
		else if (phase == phIdle)
		begin
			rxPend <= 1'b0;
			wrStrobe <= 1'b0;
		end
		else
		begin
			rxPend <= accept;
			wrStrobe <= rxPend;
		end
	end

	// write data follows the strobe pipe
	always_ff @(posedge clock)
	begin
		if (accept)
			rxData <= rxByte;
		if (rxPend)
			wrData <= rxData;
	end

	// release byte first, then read data straight from the frs
	assign loadValid = (state == xsStart) || (state == xsLoad);
	assign loadByte = (state == xsLoad) ? frsRdByte : WaitReleaseByte;

	// frs bus, strobes off once the phase has left transfer
	always_comb
	begin
		frs.addr = FrsBusAddrWidth'(addrCnt);
		frs.wrByte = wrData;
		frs.wrStrobe = wrStrobe && inTransfer;
		frs.rdStrobe = (state == xsReadStrobe) && inTransfer;
	end

	// write pipe and read state never overlap
	assert property (@(posedge clock) disable iff (!reset_n)
		!(frs.wrStrobe && frs.rdStrobe));

endmodule

/* rtl/txResponder.sv */
/*
 * Transmit responder. Holds one outgoing byte and runs the
 * prepare, valid and ack exchange with the serializer.
 */
`timescale 1ns/1ns

module txResponder
(
	input logic clock,
	input logic reset_n,
	input tpmCtrlPkg::ctrlPhase_t phase,
	input spiProtocolPkg::byte_t loadByte,
	input logic loadValid,
	input logic txPrepare,
	input logic txAck,
	output spiProtocolPkg::byte_t txByte,
	output logic txValid,
	output logic sent	// one cycle after ack
);
	import spiProtocolPkg::*;
	import tpmCtrlPkg::*;

	txState_t state;
	byte_t holdByte;	// pending outgoing byte
	logic inTransfer;

	assign inTransfer = (phase == phTransfer);

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= rsEmpty;
			sent <= 1'b0;
			holdByte <= '0;
		end
		else if (phase == phIdle)
		begin
			state <= rsEmpty;	// drop any pending byte
			sent <= 1'b0;
		end
		else
		begin
			sent <= 1'b0;
			case (state)
				rsEmpty:
					if (loadValid)
					begin
						holdByte <= loadByte;
						state <= rsHold;
					end
				rsHold:
					if (txPrepare)
						state <= rsArm;	// prepare only counts with a byte held
				rsArm:
					state <= rsFire;
				rsFire:
					state <= rsValid;	// valid on second edge after prepare
				rsValid, rsAck:
					if (txAck)
					begin
						state <= rsEmpty;
						sent <= 1'b1;
					end
					else
						state <= rsAck;	// waits as long as needed
				default:
					state <= rsEmpty;
			endcase
		end
	end

	assign txValid = (state == rsValid) && inTransfer;
	assign txByte = inTransfer ? holdByte : '0;

	// engine loads only after sent
	assert property (@(posedge clock) disable iff (!reset_n)
		(loadValid && inTransfer) |-> (state == rsEmpty));

	// single-cycle valid per byte
	assert property (@(posedge clock) disable iff (!reset_n)
		txValid |=> !txValid);

endmodule

/* verification/clockGen.sv */
/*
 * Testbench clock and reset source.
 * Free-running clock, reset held low for the first cycles.
 */
`timescale 1ns/1ns

module clockGen
#(
	parameter int Period = 100,	// ns
	parameter int ResetCycles = 2
)
(
	output logic clock,
	output logic reset_n
);
	initial
	begin
		clock = 1'b0;
		forever
			#(Period / 2) clock = ~clock;
	end

	initial
	begin
		reset_n = 1'b0;
		repeat (ResetCycles)
			@(posedge clock);
		#10 reset_n = 1'b1;	// released off the edge
	end

endmodule

/* verification/tpmSpiCtrlTb.sv */
/*
 * Testbench for the TPM-over-SPI controller.
 * Serializer and register file models, random transactions
 * from a fixed seed, checked against a header-rule model.
 */
`timescale 1ns/1ns

module tpmSpiCtrlTb;
	import spiProtocolPkg::*;
	import tpmCtrlPkg::*;

	logic clock;
	logic reset_n;
	logic csN;
	byte_t rxByte;
	logic rxValid;
	logic txPrepare;
	logic txAck;
	byte_t frsRdByte;
	byte_t txByte;
	logic txValid;
	frsAccess_t frs;

	byte_t mem [int];	// register file contents
	logic [15:0] wrAddrQ[$];	// observed write strobes
	byte_t wrDataQ[$];
	int rdCount = 0;
	bit rdPending = 0;
	logic [15:0] rdAddr;
	bit prevValid = 0;
	bit validSeen = 0;
	byte_t validByte;
	int validTotal = 0;	// txValid cycles seen
	int delayMax = 3;	// serializer response spread
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;

	clockGen #(.Period(100), .ResetCycles(2)) i_clockGen (.clock(clock), .reset_n(reset_n));

	tpmSpiCtrl #(.FrsAddrWidth(16)) i_dut (
		.clock(clock), .reset_n(reset_n), .csN(csN),
		.rxByte(rxByte), .rxValid(rxValid), .txPrepare(txPrepare), .txAck(txAck),
		.frsRdByte(frsRdByte), .txByte(txByte), .txValid(txValid), .frs(frs)
	);

	// unwritten locations, pattern over the whole address
	function automatic byte_t memRead(logic [15:0] a);
		if (mem.exists(a))
			return mem[a];
		return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h5A;
	endfunction

	// frs strobes sampled mid-cycle
	always @(negedge clock)
	begin
		if (frs.wrStrobe)
		begin
			wrAddrQ.push_back(frs.addr);
			wrDataQ.push_back(frs.wrByte);
			mem[frs.addr] = frs.wrByte;
		end
		if (frs.rdStrobe)
		begin
			rdCount++;
			rdPending = 1;
			rdAddr = frs.addr;
		end
	end

	// read data one cycle after the strobe
	always @(posedge clock)
	begin
		if (rdPending)
		begin
			rdPending = 0;
			#10 frsRdByte = memRead(rdAddr);
		end
	end

	task automatic abortRun(string what);
		$display("timeout: no %s within the allowed cycles", what);
		$display("sim failed");
		$finish;
	endtask

	// one cycle, outputs sampled before new inputs go out
	task automatic step();
		@(posedge clock);
		#10;
		if (txValid)
		begin
			assert (!prevValid)
			else
			begin
				$display("ERR %0t: txValid held longer than one cycle", $time);
				errorCount++;
			end
			validSeen = 1;
			validByte = txByte;
			validTotal++;
		end
		prevValid = txValid;
	endtask

	task automatic checkByte(string what, byte_t got, byte_t exp);
		checkCount++;
		assert (got == exp)
		else
		begin
			$display("ERR %0t: %s got %02h expected %02h", $time, what, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkIdle();
		checkCount++;
		assert (!txValid && !frs.wrStrobe && !frs.rdStrobe && txByte == 8'h00)
		else
		begin
			$display("ERR %0t: outputs not idle", $time);
			errorCount++;
		end
	endtask

	task automatic sendByte(byte_t b);
		repeat ($urandom_range(0, 3))
			step();
		rxByte = b;
		rxValid = 1'b1;
		step();
		rxValid = 1'b0;
	endtask

	// serializer side of prepare, valid and ack
	task automatic getTxByte(output byte_t b);
		int tries;
		int w;
		bit got;
		got = 0;
		validSeen = 0;
		for (tries = 0; tries < 40 && !got; tries++)
		begin
			repeat ($urandom_range(0, delayMax))
				step();
			txPrepare = 1'b1;
			step();
			txPrepare = 1'b0;
			for (w = 0; w < 8 && !validSeen; w++)
				step();
			got = validSeen;
		end
		if (!got)
			abortRun("txValid after txPrepare");
		b = validByte;
		repeat ($urandom_range(0, delayMax))
			step();
		txAck = 1'b1;
		step();
		txAck = 1'b0;
	endtask

	// one transaction, abortAt >= 0 raises csN before that data byte
	task automatic runTransaction(bit rd, int size, logic [23:0] addr, int abortAt);
		logic [31:0] hdr;
		logic [15:0] base;
		byte_t data[$];
		byte_t b;
		int i;
		int vMark;
		int wrMark;
		int rdMark;
		hdr = {rd, 1'b0, 6'(size), addr};
		base = addr[15:0];
		wrAddrQ.delete();
		wrDataQ.delete();
		csN = 1'b0;
		step();
		step();	// phase in header
		for (i = 0; i < HeaderBytes; i++)
			sendByte(hdr[31 - 8 * i -: 8]);
		getTxByte(b);
		checkByte("release byte", b, 8'hFF);
		repeat (3)
			step();	// engine into its loop
		vMark = validTotal;
		for (i = 0; i <= size && i != abortAt; i++)
		begin
			if (!rd)
			begin
				data.push_back(byte_t'($urandom));
				sendByte(data[i]);
			end
			else
			begin
				getTxByte(b);
				checkByte("read byte", b, memRead(16'(base + i)));
			end
		end
		if (abortAt >= 0)
		begin
			csN = 1'b1;
			step();	// pipe may drain on this edge
			wrMark = wrAddrQ.size();
			rdMark = rdCount;
			vMark = validTotal;
			repeat (10)
				step();
			checkCount++;
			assert (wrAddrQ.size() == wrMark && rdCount == rdMark && validTotal == vMark)
			else
			begin
				$display("ERR %0t: activity after abort", $time);
				errorCount++;
			end
		end
		else if (!rd)
		begin
			sendByte(byte_t'($urandom));	// one byte past the end, never written
			for (i = 0; i < 30 && wrAddrQ.size() < size + 1; i++)
				step();
			if (wrAddrQ.size() < size + 1)
				abortRun("complete set of write strobes");
			repeat (5)
				step();
			checkCount++;
			assert (wrAddrQ.size() == size + 1 && validTotal == vMark)
			else
			begin
				$display("ERR %0t: %0d writes for %0d bytes", $time, wrAddrQ.size(), size + 1);
				errorCount++;
			end
			for (i = 0; i <= size; i++)
			begin
				checkByte("write data", wrDataQ[i], data[i]);
				checkCount++;
				assert (wrAddrQ[i] == 16'(base + i))
				else
				begin
					$display("ERR %0t: write %0d at %04h", $time, i, wrAddrQ[i]);
					errorCount++;
				end
			end
		end
		else
		begin
			vMark = validTotal;
			repeat (20)
			begin
				txPrepare = 1'b1;	// prepares with nothing pending
				step();
				txPrepare = 1'b0;
				step();
			end
			checkCount++;
			assert (validTotal == vMark)
			else
			begin
				$display("ERR %0t: extra txValid after last read byte", $time);
				errorCount++;
			end
		end
		csN = 1'b1;
		repeat (3)
			step();
		checkIdle();
	endtask

	task automatic endTest(string name, int errBefore);
		testCount++;
		if (errorCount == errBefore)
			$display("test %s: ok", name);
		else
			$display("test %s: FAILED with %0d errors", name, errorCount - errBefore);
	endtask

	task automatic preload(logic [23:0] addr);
		int i;
		for (i = 0; i < 64; i++)
			mem[16'(addr[15:0] + i)] = byte_t'($urandom);
	endtask

	initial
	begin
		int e;
		int i;
		int w;
		logic [23:0] a;
		csN = 1'b1;
		rxByte = '0;
		rxValid = 1'b0;
		txPrepare = 1'b0;
		txAck = 1'b0;
		frsRdByte = '0;
		void'($urandom(32'he1d3));
		for (w = 0; w < 10 && !reset_n; w++)
			step();
		if (!reset_n)
			abortRun("reset release");
		e = errorCount;
		step();
		checkIdle();
		endTest("reset", e);
		e = errorCount;
		for (i = 0; i < 4; i++)
			runTransaction(0, $urandom_range(0, 15), 24'($urandom), -1);
		endTest("random writes", e);
		e = errorCount;
		for (i = 0; i < 4; i++)
		begin
			a = 24'($urandom);
			preload(a);
			runTransaction(1, $urandom_range(0, 15), a, -1);
		end
		endTest("random reads", e);
		e = errorCount;
		delayMax = 20;	// slow serializer
		runTransaction(0, 7, 24'($urandom), -1);
		a = 24'($urandom);
		preload(a);
		runTransaction(1, 7, a, -1);
		delayMax = 3;
		endTest("back-pressure", e);
		e = errorCount;
		runTransaction(0, 12, 24'($urandom), 5);
		a = 24'($urandom);
		preload(a);
		runTransaction(1, 9, a, -1);
		runTransaction(1, 12, a, 4);
		runTransaction(0, 9, 24'($urandom), -1);
		endTest("abort", e);
		e = errorCount;
		a = 24'hFFFFF0;	// wraps the low address bits
		preload(a);
		runTransaction(0, 0, a, -1);
		runTransaction(1, 0, a, -1);
		runTransaction(0, 63, a, -1);
		runTransaction(1, 63, a, -1);
		endTest("size extremes", e);
		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
